// File: if_stage_top.f
src/riscv_isa_pkg.sv
src/fetch_pkg.sv
src/pc_select.sv
src/instr_fetch.sv
src/c_expander.sv
src/if_id_reg.sv
src/if_stage_top.sv
verif/instr_mem_model.sv
verif/tb_if_stage_top.sv

// File: Bender.yml
package:
  name: if_stage

sources:
  # Packages first, then RTL bottom-up
  - src/riscv_isa_pkg.sv
  - src/fetch_pkg.sv
  - src/pc_select.sv
  - src/instr_fetch.sv
  - src/c_expander.sv
  - src/if_id_reg.sv
  - src/if_stage_top.sv
  - target: test
    files:
      - verif/instr_mem_model.sv
      - verif/tb_if_stage_top.sv

// File: verif/tb_if_stage_top.sv
// Testbench for the IF stage, random program with redirects, ID stalls and halts against a reference
`timescale 1ns/1ps

module tb_if_stage_top;

  import riscv_isa_pkg::*;
  import fetch_pkg::*;

  localparam int num_seg     = 12;  // One redirect each
  localparam int seg_len     = 20;  // Instructions accepted per segment
  localparam int total_instr = num_seg * seg_len;
  localparam int max_cycles  = 20 * total_instr;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic            compressed;
    logic            illegal;
  } exp_instr_t;

  logic        clk;
  logic        rst_n;
  if_ctrl_t    ctrl_i;
  targets_t    targets_i;
  fetch_req_t  instr_req;
  logic        instr_gnt;
  fetch_rsp_t  instr_rsp;
  logic        id_ready;
  if_id_pipe_t pipe;
  logic        if_busy;
  logic        mtvec_init;

  // Checker state
  logic [xlen-1:0] exp_pc     = '0;
  int              seg_cnt    = 0;  // Accepted since last redirect
  int              n_checked  = 0;
  int              err_data   = 0;
  int              err_ctrl   = 0;
  int              cycle_cnt  = 0;
  logic            booted     = 1'b0;
  if_id_pipe_t     pipe_prev;
  logic            stall_prev = 1'b0;  // Valid output held last edge
  logic            halt_prev  = 1'b0;
  logic            gnt_prev   = 1'b0;  // Granted last edge, response due now
  logic            wait_prev  = 1'b0;  // Request left waiting for gnt last edge
  logic [xlen-1:0] addr_prev  = '0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  if_stage_top #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_if_stage_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .instr_req_o      (instr_req),
    .instr_gnt_i      (instr_gnt),
    .instr_rsp_i      (instr_rsp),
    .id_ready_i       (id_ready),
    .if_id_pipe_o     (pipe),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (mtvec_init)
  );

  instr_mem_model u_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .req_i (instr_req),
    .gnt_o (instr_gnt),
    .rsp_o (instr_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [xlen-1:0] ref_target(if_ctrl_t c, targets_t t);
    logic [xlen-1:0] base;
    base = {t.mtvec_base, 7'b0};   // 128-byte aligned table
    case (c.pc_mux)
      pc_boot:     return t.boot_addr & ~32'h3;
      pc_jump:     return t.jump_target & ~32'h1;
      pc_branch:   return t.branch_target & ~32'h1;
      pc_mret:     return t.mepc & ~32'h1;
      pc_trap_exc: return base;
      pc_trap_irq: return base + 32'(c.irq_id) * 4;
      default:     return 'x;
    endcase
  endfunction

  function automatic exp_instr_t ref_expand(logic [xlen-1:0] word);
    logic [15:0]     hw;
    logic [4:0]      rd;
    logic [4:0]      rs2;
    logic [4:0]      rdp;
    logic [4:0]      rs1p;
    logic [xlen-1:0] imm;
    exp_instr_t      e;
    hw   = word[15:0];
    rd   = hw[11:7];
    rs2  = hw[6:2];
    rdp  = 5'd8 + 5'(hw[4:2]);     // x8..x15
    rs1p = 5'd8 + 5'(hw[9:7]);
    e    = '{instr: {16'h0, hw}, compressed: 1'b1, illegal: 1'b1};
    if (hw[1:0] == 2'b11) begin
      e = '{instr: word, compressed: 1'b0, illegal: 1'b0};
    end else begin
      case ({hw[15:13], hw[1:0]})
        5'b000_01: begin           // C.ADDI, addi rd, rd, imm
          imm = {{26{hw[12]}}, hw[12], hw[6:2]};
          e.instr   = {imm[11:0], rd, 3'b000, rd, 7'b0010011};
          e.illegal = 1'b0;
        end
        5'b010_01: begin           // C.LI, addi rd, x0, imm
          imm = {{26{hw[12]}}, hw[12], hw[6:2]};
          e.instr   = {imm[11:0], 5'd0, 3'b000, rd, 7'b0010011};
          e.illegal = 1'b0;
        end
        5'b101_01: begin           // C.J, jal x0, offset
          imm = {{20{hw[12]}}, hw[12], hw[8], hw[10:9], hw[6], hw[7], hw[2],
                 hw[11], hw[5:3], 1'b0};
          e.instr   = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
          e.illegal = 1'b0;
        end
        5'b010_00: begin           // C.LW
          imm = {25'd0, hw[5], hw[12:10], hw[6], 2'b00};
          e.instr   = {imm[11:0], rs1p, 3'b010, rdp, 7'b0000011};
          e.illegal = 1'b0;
        end
        5'b110_00: begin           // C.SW
          imm = {25'd0, hw[5], hw[12:10], hw[6], 2'b00};
          e.instr   = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'b0100011};
          e.illegal = 1'b0;
        end
        5'b100_10: begin           // C.ADD and C.MV, rs2 of x0 is another group
          if (rs2 != 5'd0) begin
            e.instr   = {7'd0, rs2, (hw[12] ? rd : 5'd0), 3'b000, rd, 7'b0110011};
            e.illegal = 1'b0;
          end
        end
        default: begin
        end
      endcase
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checker, samples at the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [xlen-1:0] word;
    exp_instr_t      e;
    if (!rst_n) begin
      if (instr_req.req || pipe.valid || mtvec_init) begin
        err_ctrl++;
        $display("ERR %0t: outputs active during reset", $time);
      end
    end else begin
      if (!booted && instr_req.req) begin
        err_ctrl++;
        $display("ERR %0t: request before boot redirect", $time);
      end
      if (mtvec_init !== (ctrl_i.pc_set && (ctrl_i.pc_mux == pc_boot))) begin
        err_ctrl++;
        $display("ERR %0t: csr_mtvec_init_o is %b", $time, mtvec_init);
      end
      if (ctrl_i.halt_if && instr_req.req) begin
        err_ctrl++;
        $display("ERR %0t: request issued while halted", $time);
      end
      // Busy covers a waiting request and the response cycle after a grant
      if (if_busy !== (instr_req.req || gnt_prev)) begin
        err_ctrl++;
        $display("ERR %0t: if_busy_o is %b, expected %b", $time, if_busy,
                 instr_req.req || gnt_prev);
      end
      if (wait_prev && instr_req.req && (instr_req.addr !== addr_prev)) begin
        err_ctrl++;
        $display("ERR %0t: addr %h changed from %h before gnt", $time,
                 instr_req.addr, addr_prev);
      end
      if (stall_prev && (pipe !== pipe_prev)) begin
        err_ctrl++;
        $display("ERR %0t: pipe output changed under stall", $time);
      end
      if (halt_prev && pipe.valid && !stall_prev) begin
        err_ctrl++;
        $display("ERR %0t: new valid while halted", $time);
      end
      if (pipe.valid && id_ready) begin       // ID takes it at this edge
        word = u_mem.read_word(exp_pc);
        e    = ref_expand(word);
        if (pipe.pc !== exp_pc) begin
          err_data++;
          $display("ERR %0t: pc %h, expected %h", $time, pipe.pc, exp_pc);
        end
        if (pipe.instr !== e.instr) begin
          err_data++;
          $display("ERR %0t: instr %h, expected %h at pc %h", $time, pipe.instr, e.instr,
                   exp_pc);
        end
        if ((pipe.compressed !== e.compressed) || (pipe.illegal_c !== e.illegal)) begin
          err_data++;
          $display("ERR %0t: flags c=%b ill=%b, expected c=%b ill=%b", $time,
                   pipe.compressed, pipe.illegal_c, e.compressed, e.illegal);
        end
        if (pipe.raw_c !== word[15:0]) begin
          err_data++;
          $display("ERR %0t: raw_c %h, expected %h", $time, pipe.raw_c, word[15:0]);
        end
        exp_pc = exp_pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
        seg_cnt++;
        n_checked++;
      end
      if (ctrl_i.pc_set) begin                // New stream starts at the target
        exp_pc  = ref_target(ctrl_i, targets_i);
        seg_cnt = 0;
        if (ctrl_i.pc_mux == pc_boot) begin
          booted = 1'b1;
        end
      end
    end
    pipe_prev  = pipe;
    stall_prev = pipe.valid && !id_ready;
    halt_prev  = ctrl_i.halt_if;
    gnt_prev   = instr_req.req && instr_gnt;
    wait_prev  = instr_req.req && !instr_gnt;
    addr_prev  = instr_req.addr;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout after %0d cycles, only %0d instructions accepted", cycle_cnt,
               n_checked);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus, driven on the falling edge
  ////////////////////////////////////////////////////////////

  // Redirect, then let ID accept seg_len instructions of the new stream
  task automatic run_segment(pc_mux_e mux, bit with_halt);
    bit halt_done;
    halt_done                 = 1'b0;
    targets_i.boot_addr       = $urandom;
    targets_i.jump_target     = $urandom;
    targets_i.branch_target   = $urandom;
    targets_i.mepc            = $urandom;
    targets_i.mtvec_base      = 25'($urandom);
    ctrl_i.pc_set             = 1'b1;
    ctrl_i.pc_mux             = mux;
    ctrl_i.irq_id             = IRQ_ID_W'($urandom_range(0, 31));
    ctrl_i.halt_if            = 1'b0;
    id_ready                  = 1'b1;  // Old pipe entry leaves with the redirect
    @(negedge clk);
    ctrl_i.pc_set = 1'b0;
    while (seg_cnt < seg_len) begin
      if (with_halt && !halt_done && (seg_cnt >= seg_len / 2)) begin
        ctrl_i.halt_if = 1'b1;
        repeat (8) begin
          id_ready = ($urandom_range(0, 9) < 7);
          @(negedge clk);
        end
        ctrl_i.halt_if = 1'b0;
        halt_done      = 1'b1;
      end
      id_ready = ($urandom_range(0, 9) < 7);  // Random ID stalls
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(5));
    rst_n     = 1'b0;
    ctrl_i    = '0;
    targets_i = '0;
    id_ready  = 1'b0;
    u_mem.fill_random();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);      // Idle, nothing may be fetched yet
    for (int s = 0; s < num_seg; s++) begin
      // Boot first, then jump, branch, mret, exception, interrupt in turn
      run_segment((s == 0) ? pc_boot : pc_mux_e'(3'(1 + (s - 1) % 5)), (s % 3 == 2));
    end
    id_ready = 1'b0;
    repeat (4) @(negedge clk);
    $display("Errors: data %0d, control %0d, instructions checked %0d", err_data,
             err_ctrl, n_checked);
    if ((err_data == 0) && (err_ctrl == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verif/instr_mem_model.sv
// Halfword instruction memory for the IF testbench, filled at run start, grants after a random delay
`timescale 1ns/1ps

module instr_mem_model #(
  parameter int DEPTH   = 1024,  // Halfwords, addresses wrap
  parameter int NUM_DLY = 256    // Grant delay table, reused cyclically
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::fetch_req_t req_i,
  output logic                  gnt_o,
  output fetch_pkg::fetch_rsp_t rsp_o
);

  import riscv_isa_pkg::*;

  localparam int aw = $clog2(DEPTH);
  localparam int dw = $clog2(NUM_DLY);

  logic [ilen_c-1:0] mem [DEPTH];
  logic [1:0]        dly [NUM_DLY];  // 0..3 cycles before gnt
  logic [dw-1:0]     dly_idx;
  logic [1:0]        wait_cnt;       // Cycles req has waited

  // 32 bits starting at any halfword
  function automatic logic [xlen-1:0] read_word(logic [xlen-1:0] addr);
    logic [aw-1:0] idx;
    logic [aw-1:0] nxt;
    idx = addr[aw:1];
    nxt = idx + 1'b1;                // Wraps at the top
    return {mem[nxt], mem[idx]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Contents, drawn from the caller's random stream
  ////////////////////////////////////////////////////////////

  task automatic fill_random();
    logic [ilen_c-1:0] hw;
    int                kind;
    for (int i = 0; i < DEPTH; i++) begin
      hw   = 16'($urandom);
      kind = $urandom_range(0, 9);
      if (kind < 4) begin            // Supported RVC
        case ($urandom_range(0, 6))
          0: hw = {3'b000, hw[12:2], 2'b01};         // C.ADDI
          1: hw = {3'b010, hw[12:2], 2'b01};         // C.LI
          2: hw = {3'b101, hw[12:2], 2'b01};         // C.J
          3: hw = {3'b010, hw[12:2], 2'b00};         // C.LW
          4: hw = {3'b110, hw[12:2], 2'b00};         // C.SW
          5: hw = {3'b100, 1'b0, hw[11:2], 2'b10};   // C.MV
          default: hw = {3'b100, 1'b1, hw[11:2], 2'b10};  // C.ADD
        endcase
        if ((hw[1:0] == 2'b10) && (hw[6:2] == 5'd0)) begin
          hw[2] = 1'b1;              // rs2 of x0 would be JR/JALR
        end
      end else if (kind < 6) begin   // Unsupported RVC
        hw[15:13] = 3'b001;
        hw[1:0]   = 2'($urandom_range(0, 2));
        if ($urandom_range(0, 3) == 0) begin
          hw = '0;
        end
      end else begin
        hw[1:0] = 2'b11;             // Low half of a 32-bit word
      end
      mem[i] = hw;
    end
    for (int i = 0; i < NUM_DLY; i++) begin
      dly[i] = 2'($urandom_range(0, 3));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  assign gnt_o = req_i.req && (wait_cnt == dly[dly_idx]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
      dly_idx  <= '0;
      rsp_o    <= '0;
    end else begin
      rsp_o.rvalid <= 1'b0;
      if (req_i.req && gnt_o) begin
        rsp_o.rvalid <= 1'b1;        // Answer one cycle after gnt
        rsp_o.rdata  <= read_word(req_i.addr);
        wait_cnt     <= '0;
        dly_idx      <= dly_idx + 1'b1;
      end else if (req_i.req) begin
        wait_cnt <= wait_cnt + 1'b1;
      end else begin
        wait_cnt <= '0;              // Request withdrawn by a redirect
      end
    end
  end

endmodule

// File: src/if_stage_top.sv
// Instruction fetch stage top, connects target mux, bus fetch, RVC expander and IF/ID register
`timescale 1ns/1ps

module if_stage_top #(
  parameter int IRQ_ID_W = fetch_pkg::IRQ_ID_W
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fetch_pkg::if_ctrl_t    ctrl_i,
  input  fetch_pkg::targets_t    targets_i,
  output fetch_pkg::fetch_req_t  instr_req_o,
  input  logic                   instr_gnt_i,
  input  fetch_pkg::fetch_rsp_t  instr_rsp_i,
  input  logic                   id_ready_i,
  output fetch_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                   if_busy_o,
  output logic                   csr_mtvec_init_o
);

  import riscv_isa_pkg::*;

  logic [xlen-1:0] target;       // Redirect address
  logic            if_valid;
  logic            accept;       // Buffer handed to ID
  logic [xlen-1:0] fetch_pc;
  logic [xlen-1:0] fetch_word;
  logic [xlen-1:0] instr_exp;    // Expanded instruction
  logic            compressed;
  logic            illegal_c;

  assign accept = if_valid && id_ready_i;

  ////////////////////////////////////////////////////////////
  // Fetch path
  ////////////////////////////////////////////////////////////

  pc_select #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_pc_select (
    .ctrl_i       (ctrl_i),
    .targets_i    (targets_i),
    .target_o     (target),
    .mtvec_init_o (csr_mtvec_init_o)
  );

  instr_fetch u_instr_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .target_i     (target),
    .bus_req_o    (instr_req_o),
    .instr_gnt_i  (instr_gnt_i),
    .bus_rsp_i    (instr_rsp_i),
    .accept_i     (accept),
    .if_valid_o   (if_valid),
    .fetch_pc_o   (fetch_pc),
    .fetch_word_o (fetch_word),
    .busy_o       (if_busy_o)
  );

  c_expander u_c_expander (
    .word_i       (fetch_word),
    .instr_o      (instr_exp),
    .compressed_o (compressed),
    .illegal_o    (illegal_c)
  );

  // Raw halfword kept for illegal-instruction reporting in ID
  if_id_reg u_if_id_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_valid_i   (if_valid),
    .id_ready_i   (id_ready_i),
    .pc_i         (fetch_pc),
    .instr_i      (instr_exp),
    .compressed_i (compressed),
    .illegal_i    (illegal_c),
    .raw_c_i      (fetch_word[ilen_c-1:0]),
    .pipe_o       (if_id_pipe_o)
  );

endmodule

// File: src/if_id_reg.sv
// IF/ID pipeline register, loads on handshake, bubbles on empty accept, holds on stall
`timescale 1ns/1ps

module if_id_reg (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             if_valid_i,
  input  logic                             id_ready_i,
  input  logic [riscv_isa_pkg::xlen-1:0]   pc_i,
  input  logic [riscv_isa_pkg::xlen-1:0]   instr_i,
  input  logic                             compressed_i,
  input  logic                             illegal_i,
  input  logic [riscv_isa_pkg::ilen_c-1:0] raw_c_i,
  output fetch_pkg::if_id_pipe_t           pipe_o
);

  import riscv_isa_pkg::*;

  logic              valid_q;
  logic [xlen-1:0]   pc_q;
  logic [xlen-1:0]   instr_q;
  logic              compressed_q;
  logic              illegal_q;
  logic [ilen_c-1:0] raw_c_q;

  // Valid: load, bubble, or hold while ID stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (id_ready_i) begin
      valid_q <= if_valid_i;        // Low here is a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid_i && id_ready_i) begin
      pc_q         <= pc_i;
      instr_q      <= instr_i;
      compressed_q <= compressed_i;
      illegal_q    <= illegal_i;
      raw_c_q      <= raw_c_i;
    end
  end

  assign pipe_o = '{valid:      valid_q,
                    pc:         pc_q,
                    instr:      instr_q,
                    compressed: compressed_q,
                    illegal_c:  illegal_q,
                    raw_c:      raw_c_q};

endmodule

// File: src/c_expander.sv
// RVC to RV32I expander for the supported compressed subset, sits between fetch buffer and IF/ID
`timescale 1ns/1ps

module c_expander (
  input  logic [riscv_isa_pkg::xlen-1:0] word_i,
  output logic [riscv_isa_pkg::xlen-1:0] instr_o,
  output logic                           compressed_o,
  output logic                           illegal_o
);

  import riscv_isa_pkg::*;

  logic [ilen_c-1:0] hw;        // Low halfword
  logic [1:0]        quad;
  logic [2:0]        funct3;
  logic [4:0]        rd;        // Full register fields
  logic [4:0]        rs2;
  logic [4:0]        rd_p;      // Three-bit fields, x8..x15
  logic [4:0]        rs1_p;
  logic [11:0]       imm_ci;    // Sign-extended 6-bit immediate
  logic [11:0]       off_lsw;   // Word offset for C.LW/C.SW

  assign hw     = word_i[ilen_c-1:0];
  assign quad   = hw[1:0];
  assign funct3 = hw[15:13];
  assign rd     = hw[11:7];
  assign rs2    = hw[6:2];
  assign rd_p   = {c_rp_prefix, hw[4:2]};
  assign rs1_p  = {c_rp_prefix, hw[9:7]};

  assign imm_ci  = {{6{hw[12]}}, hw[12], hw[6:2]};
  assign off_lsw = {5'b0, hw[5], hw[12:10], hw[6], 2'b00};  // uimm[6|5:3|2]

  ////////////////////////////////////////////////////////////
  // Expansion
  ////////////////////////////////////////////////////////////

  always_comb begin
    instr_o      = word_i;          // 32-bit words pass through
    compressed_o = 1'b0;
    illegal_o    = 1'b0;

    if (quad != 2'b11) begin
      compressed_o = 1'b1;
      // Unsupported unless a case below claims it
      instr_o      = {{(xlen-ilen_c){1'b0}}, hw};
      illegal_o    = 1'b1;

      case (quad)
        q0: begin
          if (funct3 == c_f3_lw) begin
            instr_o   = {off_lsw, rs1_p, f3_lw, rd_p, opc_load};
            illegal_o = 1'b0;
          end else if (funct3 == c_f3_sw) begin
            // rs2' sits where rd' is for C.LW
            instr_o   = {off_lsw[11:5], rd_p, rs1_p, f3_sw, off_lsw[4:0], opc_store};
            illegal_o = 1'b0;
          end
        end

        q1: begin
          if (funct3 == c_f3_addi) begin
            instr_o   = {imm_ci, rd, f3_addi, rd, opc_op_imm};  // addi rd, rd, imm
            illegal_o = 1'b0;
          end else if (funct3 == c_f3_li) begin
            instr_o   = {imm_ci, reg_x0, f3_addi, rd, opc_op_imm};  // addi rd, x0, imm
            illegal_o = 1'b0;
          end else if (funct3 == c_f3_j) begin
            // jal x0, offset[11|4|9:8|10|6|7|3:1|5]
            instr_o   = {hw[12], hw[8], hw[10:9], hw[6], hw[7], hw[2], hw[11],
                         hw[5:3], {9{hw[12]}}, reg_x0, opc_jal};
            illegal_o = 1'b0;
          end
        end

        q2: begin
          // rs2 == x0 encodes JR/JALR/EBREAK, not handled here
          if ((funct3 == c_f3_mv_add) && (rs2 != reg_x0)) begin
            if (hw[12]) begin
              instr_o = {f7_add, rs2, rd, f3_add, rd, opc_op};      // C.ADD
            end else begin
              instr_o = {f7_add, rs2, reg_x0, f3_add, rd, opc_op};  // C.MV
            end
            illegal_o = 1'b0;
          end
        end

        default: begin
        end
      endcase
    end
  end

endmodule

// File: src/instr_fetch.sv
// Single-outstanding instruction bus master with a one-word holding buffer, used inside the IF stage
`timescale 1ns/1ps

module instr_fetch (
  input  logic                            clk,
  input  logic                            rst_n,
  input  fetch_pkg::if_ctrl_t             ctrl_i,
  input  logic [riscv_isa_pkg::xlen-1:0]  target_i,
  output fetch_pkg::fetch_req_t           bus_req_o,
  input  logic                            instr_gnt_i,
  input  fetch_pkg::fetch_rsp_t           bus_rsp_i,
  input  logic                            accept_i,      // ID takes the buffer this cycle
  output logic                            if_valid_o,
  output logic [riscv_isa_pkg::xlen-1:0]  fetch_pc_o,
  output logic [riscv_isa_pkg::xlen-1:0]  fetch_word_o,
  output logic                            busy_o
);

  import riscv_isa_pkg::*;
  import fetch_pkg::*;

  logic            active_q;     // Set by the boot redirect
  logic [xlen-1:0] pc_q;         // Address of next or outstanding fetch
  logic            pend_q;       // Granted, response not yet seen
  logic            discard_q;    // Pending response belongs to old stream
  logic            buf_valid_q;
  logic [xlen-1:0] buf_word_q;
  logic [xlen-1:0] buf_pc_q;

  logic            redirect;     // pc_set or kill_if
  logic            req;
  logic            rsp_take;     // Response goes into the buffer
  logic [xlen-1:0] pc_step;

  assign redirect = ctrl_i.pc_set || ctrl_i.kill_if;

  // New request only when there is room and nothing in flight
  assign req = active_q && !ctrl_i.halt_if && !redirect && !pend_q &&
               (!buf_valid_q || accept_i);

  assign rsp_take = bus_rsp_i.rvalid && pend_q && !discard_q && !redirect;

  // Length from the low two bits of the fetched word
  assign pc_step = (bus_rsp_i.rdata[1:0] == 2'b11) ? xlen'(4) : xlen'(2);

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q    <= 1'b0;
      pc_q        <= '0;
      pend_q      <= 1'b0;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (ctrl_i.pc_set && (ctrl_i.pc_mux == pc_boot)) begin
        active_q <= 1'b1;
      end

      if (ctrl_i.pc_set) begin
        pc_q <= target_i;           // Restart the stream
      end else if (rsp_take) begin
        pc_q <= pc_q + pc_step;
      end

      if (req && instr_gnt_i) begin
        pend_q <= 1'b1;
      end else if (bus_rsp_i.rvalid) begin
        pend_q <= 1'b0;
      end

      if (bus_rsp_i.rvalid) begin
        discard_q <= 1'b0;          // Stale word has gone by
      end else if (redirect && pend_q) begin
        discard_q <= 1'b1;
      end

      if (redirect) begin
        buf_valid_q <= 1'b0;
      end else if (rsp_take) begin
        buf_valid_q <= 1'b1;
      end else if (accept_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Holding buffer payload
  always_ff @(posedge clk) begin
    if (rsp_take) begin
      buf_word_q <= bus_rsp_i.rdata;
      buf_pc_q   <= pc_q;           // pc_q still holds the request address
    end
  end

  assign bus_req_o.req  = req;
  assign bus_req_o.addr = pc_q;     // Stable until granted

  assign if_valid_o   = buf_valid_q && !ctrl_i.halt_if && !redirect;
  assign fetch_pc_o   = buf_pc_q;
  assign fetch_word_o = buf_word_q;
  assign busy_o       = req || pend_q;

endmodule

// File: src/pc_select.sv
// Next-fetch-target mux, picks the redirect address from the controller selector
`timescale 1ns/1ps

module pc_select #(
  parameter int IRQ_ID_W = fetch_pkg::IRQ_ID_W
) (
  input  fetch_pkg::if_ctrl_t             ctrl_i,
  input  fetch_pkg::targets_t             targets_i,
  output logic [riscv_isa_pkg::xlen-1:0]  target_o,
  output logic                            mtvec_init_o
);

  import riscv_isa_pkg::*;
  import fetch_pkg::*;

  logic [xlen-1:0]     mtvec_addr;  // Table base, low bits zero
  logic [IRQ_ID_W-1:0] irq_id;
  logic [xlen-1:0]     irq_off;     // 4 bytes per vector entry

  assign mtvec_addr = {targets_i.mtvec_base, {(xlen-mtvec_base_w){1'b0}}};
  assign irq_id     = ctrl_i.irq_id[IRQ_ID_W-1:0];
  assign irq_off    = xlen'({irq_id, 2'b00});

  ////////////////////////////////////////////////////////////
  // Target mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.pc_mux)
      pc_boot: begin
        target_o = {targets_i.boot_addr[xlen-1:2], 2'b00};  // Word aligned
      end
      pc_jump: begin
        target_o = {targets_i.jump_target[xlen-1:1], 1'b0};
      end
      pc_branch: begin
        target_o = {targets_i.branch_target[xlen-1:1], 1'b0};
      end
      pc_mret: begin
        target_o = {targets_i.mepc[xlen-1:1], 1'b0};  // Back to trapped PC
      end
      pc_trap_exc: begin
        target_o = mtvec_addr;  // All exceptions share the base
      end
      pc_trap_irq: begin
        // Base is 128-byte aligned so the add never carries into it
        target_o = mtvec_addr + irq_off;
      end
      default: begin
        target_o = {targets_i.boot_addr[xlen-1:2], 2'b00};
      end
    endcase
  end

  // CSR file loads mtvec on the boot redirect
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == pc_boot);

endmodule

// File: src/fetch_pkg.sv
// Fetch-stage control, bus and pipeline types, imported by the IF stage modules and testbench
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int IRQ_ID_W     = 5;   // Default interrupt id width
  localparam int mtvec_base_w = 25;  // mtvec base bits, 128-byte aligned table

  ////////////////////////////////////////////////////////////
  // Controller to IF
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    pc_boot     = 3'd0,
    pc_jump     = 3'd1,
    pc_branch   = 3'd2,
    pc_mret     = 3'd3,
    pc_trap_exc = 3'd4,
    pc_trap_irq = 3'd5
  } pc_mux_e;

  typedef struct packed {
    logic                pc_set;   // One-cycle redirect strobe
    pc_mux_e             pc_mux;   // Redirect source
    logic [IRQ_ID_W-1:0] irq_id;   // Vector index for pc_trap_irq
    logic                kill_if;  // Flush buffer and pending response
    logic                halt_if;  // Freeze output and requests
  } if_ctrl_t;

  typedef struct packed {
    logic [riscv_isa_pkg::xlen-1:0] boot_addr;
    logic [riscv_isa_pkg::xlen-1:0] jump_target;
    logic [riscv_isa_pkg::xlen-1:0] branch_target;
    logic [riscv_isa_pkg::xlen-1:0] mepc;
    logic [mtvec_base_w-1:0]        mtvec_base;
  } targets_t;

  ////////////////////////////////////////////////////////////
  // Instruction bus, gnt travels on its own wire
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                           req;
    logic [riscv_isa_pkg::xlen-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic                           rvalid;  // One cycle after gnt
    logic [riscv_isa_pkg::xlen-1:0] rdata;
  } fetch_rsp_t;

  // IF/ID register contents
  typedef struct packed {
    logic                             valid;
    logic [riscv_isa_pkg::xlen-1:0]   pc;
    logic [riscv_isa_pkg::xlen-1:0]   instr;       // Expanded form
    logic                             compressed;
    logic                             illegal_c;   // Unsupported RVC encoding
    logic [riscv_isa_pkg::ilen_c-1:0] raw_c;       // Original halfword
  } if_id_pipe_t;

endpackage

// File: src/riscv_isa_pkg.sv
// RV32I/RVC encoding constants shared by the fetch stage, imported where instructions are built
package riscv_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int xlen   = 32;  // Data and address width
  localparam int ilen_c = 16;  // Compressed instruction width

  ////////////////////////////////////////////////////////////
  // RV32I major opcodes and function codes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] opc_op_imm = 7'b0010011;  // ADDI and friends
  localparam logic [6:0] opc_op     = 7'b0110011;  // Register-register ALU
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  localparam logic [2:0] f3_addi = 3'b000;
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_lw   = 3'b010;  // Word access
  localparam logic [2:0] f3_sw   = 3'b010;
  localparam logic [6:0] f7_add  = 7'b0000000;

  ////////////////////////////////////////////////////////////
  // Compressed encodings
  ////////////////////////////////////////////////////////////

  // Quadrant in bits [1:0], 2'b11 means a full 32-bit word
  localparam logic [1:0] q0 = 2'b00;
  localparam logic [1:0] q1 = 2'b01;
  localparam logic [1:0] q2 = 2'b10;

  // funct3 in bits [15:13], meaning depends on quadrant
  localparam logic [2:0] c_f3_addi   = 3'b000;  // q1
  localparam logic [2:0] c_f3_li     = 3'b010;  // q1
  localparam logic [2:0] c_f3_j      = 3'b101;  // q1
  localparam logic [2:0] c_f3_lw     = 3'b010;  // q0
  localparam logic [2:0] c_f3_sw     = 3'b110;  // q0
  localparam logic [2:0] c_f3_mv_add = 3'b100;  // q2, bit 12 picks MV or ADD

  ////////////////////////////////////////////////////////////
  // Register fields
  ////////////////////////////////////////////////////////////

  localparam logic [4:0] reg_x0      = 5'd0;   // Hardwired zero
  localparam logic [1:0] c_rp_prefix = 2'b01;  // Three-bit fields map to x8..x15

endpackage
